// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = dzRegsTb
FILELIST   = dzRegs.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dzRegs.f
+incdir+rtl
rtl/dzPkg.sv
rtl/dzCsr.sv
rtl/dzTcr.sv
rtl/dzLineRegs.sv
rtl/dzRegs.sv
verif/dzRegsTb.sv

// File: rtl/dzCfg.svh
//////////////////////////////////////////////////////////////////////
// Build constants for the terminal multiplexer register block
// Include in any module that sizes lines, the bus or offsets
//////////////////////////////////////////////////////////////////////

`ifndef DZ_CFG_SVH
`define DZ_CFG_SVH

// Number of asynchronous serial lines
`define DZ_LINES 8

// I/O bus data width in bits
`define DZ_BUS_WIDTH 36

//////////////////////////////////////////////////////////////////////
// Register word offsets
//////////////////////////////////////////////////////////////////////

`define DZ_OFS_CSR 2'd0
// Write only, reads return zero
`define DZ_OFS_LPR 2'd1
`define DZ_OFS_TCR 2'd2
// TDR on write, MSR on read
`define DZ_OFS_TDR 2'd3

`endif

// File: rtl/dzCsr.sv
//////////////////////////////////////////////////////////////////////
// Control and status register with the round-robin transmit scanner
// Instantiated by the register block top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "dzCfg.svh"

module dzCsr (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          devReset,
   input  logic                          csrWrite,
   input  logic                          loByte,
   input  logic                          hiByte,
   input  logic [15:0]                   dataIn,
   input  logic [`DZ_LINES-1:0]          tcrLin,
   input  logic                          txTaken,
   output dzPkg::csrT                    csrOut,
   output logic                          csrClr,
   output logic                          mse,
   output logic [$clog2(`DZ_LINES)-1:0]  tline
);

   localparam int LINE_BITS = $clog2(`DZ_LINES);

   // Write data seen through the CSR layout
   dzPkg::csrT csrWord;

   logic                 tie;
   logic                 sae;
   logic                 rie;
   logic                 trdy;
   // Search start point for the scanner
   logic [LINE_BITS-1:0] scanPtr;

   assign csrWord = dataIn;

   // First enabled line at or after start, wrapping around
   function automatic logic [LINE_BITS-1:0] firstEnabled(
      input logic [LINE_BITS-1:0] start,
      input logic [`DZ_LINES-1:0] lin
   );
      logic [LINE_BITS-1:0] idx;
      logic [LINE_BITS-1:0] found;
      logic                 hit;
      found = start;
      hit   = 1'b0;
      for (int k = 0; k < `DZ_LINES; k++)
      begin
         idx = start + k[LINE_BITS-1:0];
         if (!hit && lin[idx])
         begin
            found = idx;
            hit   = 1'b1;
         end
      end
      return found;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Enable bits, self-clearing clr and scan pointer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || devReset)
      begin
         tie     <= 1'b0;
         sae     <= 1'b0;
         rie     <= 1'b0;
         mse     <= 1'b0;
         csrClr  <= 1'b0;
         scanPtr <= '0;
      end
      else if (csrClr)
      begin
         // Clear cycle, everything back to idle and scan from line 0
         tie     <= 1'b0;
         sae     <= 1'b0;
         rie     <= 1'b0;
         mse     <= 1'b0;
         csrClr  <= 1'b0;
         scanPtr <= '0;
      end
      else
      begin
         if (csrWrite && loByte)
         begin
            rie    <= csrWord.rie;
            mse    <= csrWord.mse;
            csrClr <= csrWord.clr;
         end
         if (csrWrite && hiByte)
         begin
            tie <= csrWord.tie;
            sae <= csrWord.sae;
         end
         // Move past the line just served
         if (txTaken)
            scanPtr <= tline + 1'b1;
      end
   end

   // Scanner output follows enable changes without delay
   assign tline = firstEnabled(scanPtr, tcrLin);

   // Not ready while the scanner steps past a served line
   assign trdy = mse && (|tcrLin) && !txTaken;

   // Receiver and maintenance bits not implemented, read as zero
   always_comb
   begin
      csrOut       = '0;
      csrOut.trdy  = trdy;
      csrOut.tie   = tie;
      csrOut.sae   = sae;
      csrOut.tline = tline;
      csrOut.rie   = rie;
      csrOut.mse   = mse;
      csrOut.clr   = csrClr;
   end

   // Ready flag must always point the transmitter at a live line
   assert property (@(posedge clk) disable iff (reset)
      csrOut.trdy |-> tcrLin[tline]);

endmodule

// File: rtl/dzLineRegs.sv
//////////////////////////////////////////////////////////////////////
// Per-line parameters, break latches and transmit character strobe
// Fed by the LPR and TDR write strobes of the register block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "dzCfg.svh"

module dzLineRegs (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          devReset,
   input  logic                          lprWrite,
   input  logic                          tdrWrite,
   input  logic                          loByte,
   input  logic                          hiByte,
   input  logic [15:0]                   dataIn,
   input  logic                          mse,
   input  logic                          trdy,
   input  logic [$clog2(`DZ_LINES)-1:0]  tline,
   output logic                          txStrobe,
   output logic [$clog2(`DZ_LINES)-1:0]  txLine,
   output logic [7:0]                    txChar,
   output logic                          txTaken,
   output logic [`DZ_LINES-1:0]          breakOut,
   output logic [`DZ_LINES-1:0]          rxEnable
);

   // Same write word, two decodes
   dzPkg::lprT  lprWord;
   dzPkg::reg6T tdrWord;

   // Line parameter table
   dzPkg::lprT  lprTable [`DZ_LINES];

   logic        txAccept;

   assign lprWord = dataIn;
   assign tdrWord = dataIn;

   //////////////////////////////////////////////////////////////////////
   // Line parameters
   //////////////////////////////////////////////////////////////////////

   // Line number sits in the low byte, so loByte addresses the entry
   always_ff @(posedge clk)
   begin
      if (reset || devReset)
      begin
         for (int i = 0; i < `DZ_LINES; i++)
            lprTable[i] <= '0;
      end
      else if (lprWrite && loByte)
      begin
         lprTable[lprWord.line][7:0] <= lprWord[7:0];
         if (hiByte)
            lprTable[lprWord.line][15:8] <= lprWord[15:8];
      end
   end

   // Receivers run only with master scan on
   always_comb
   begin
      for (int i = 0; i < `DZ_LINES; i++)
         rxEnable[i] = lprTable[i].rxOn && mse;
   end

   //////////////////////////////////////////////////////////////////////
   // Break bits and transmit strobe
   //////////////////////////////////////////////////////////////////////

   // Character only taken while the scanner has a ready line
   assign txAccept = tdrWrite && loByte && trdy;

   always_ff @(posedge clk)
   begin
      if (reset || devReset)
      begin
         breakOut <= '0;
         txStrobe <= 1'b0;
      end
      else
      begin
         if (tdrWrite && hiByte)
            breakOut <= tdrWord.tdr.brk;
         txStrobe <= txAccept;
      end
   end

   // Line and character captured with the accepted write
   always_ff @(posedge clk)
   begin
      if (txAccept)
      begin
         txLine <= tline;
         txChar <= tdrWord.tdr.chr;
      end
   end

   // Scanner steps on while the strobe is out
   assign txTaken = txStrobe;

   // Ready drops during the strobe, so no back-to-back characters
   assert property (@(posedge clk) disable iff (reset)
      txStrobe |=> !txStrobe);

endmodule

// File: rtl/dzPkg.sv
//////////////////////////////////////////////////////////////////////
// Register field layouts shared by the multiplexer register blocks
//////////////////////////////////////////////////////////////////////

package dzPkg;

   // Control and status register, bit 15 down to bit 0
   typedef struct packed {
      logic       trdy;
      logic       tie;
      logic       sa;
      logic       sae;
      logic       rsvd11;
      logic [2:0] tline;
      logic       rdone;
      logic       rie;
      logic       mse;
      logic       clr;
      logic       maint;
      logic [2:0] rsvd2to0;
   } csrT;

   // Line parameter register, one entry per line
   typedef struct packed {
      logic [2:0] rsvd15to13;
      logic       rxOn;
      logic [3:0] speed;
      logic       parOdd;
      logic       parEn;
      logic       stopBits;
      logic [1:0] charLen;
      logic [2:0] line;
   } lprT;

   // Offset 3 read side, modem status
   typedef struct packed {
      logic [7:0] carrier;
      logic [7:0] ring;
   } msrT;

   // Offset 3 write side, break bits and transmit character
   typedef struct packed {
      logic [7:0] brk;
      logic [7:0] chr;
   } tdrT;

   // Same word decoded by direction of access
   typedef union packed {
      msrT msr;
      tdrT tdr;
   } reg6T;

endpackage

// File: rtl/dzRegs.sv
//////////////////////////////////////////////////////////////////////
// Top of the terminal multiplexer register block on the 36-bit bus
// Decodes word offsets, swaps bit order and registers read data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "dzCfg.svh"

module dzRegs (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          devReset,
   input  logic                          devWrite,
   input  logic                          devRead,
   input  logic                          devLoByte,
   input  logic                          devHiByte,
   input  logic [1:0]                    devAddr,
   input  logic [0:`DZ_BUS_WIDTH-1]      devDataIn,
   output logic [0:`DZ_BUS_WIDTH-1]      devDataOut,
   output logic                          devReadValid,
   output logic                          txStrobe,
   output logic [$clog2(`DZ_LINES)-1:0]  txLine,
   output logic [7:0]                    txChar,
   output logic [`DZ_LINES-1:0]          breakOut,
   output logic [`DZ_LINES-1:0]          dtrOut,
   output logic [`DZ_LINES-1:0]          rxEnable,
   input  logic [`DZ_LINES-1:0]          carrierIn,
   input  logic [`DZ_LINES-1:0]          ringIn
);

   localparam int LINE_BITS = $clog2(`DZ_LINES);

   // Little-endian copies of the bus
   logic [`DZ_BUS_WIDTH-1:0] busIn;
   logic [`DZ_BUS_WIDTH-1:0] readData;
   logic [15:0]              wrData;

   // Per-register write strobes
   logic                     csrWrite;
   logic                     lprWrite;
   logic                     tcrWrite;
   logic                     tdrWrite;

   dzPkg::csrT               csrOut;
   dzPkg::reg6T              msrWord;
   logic [15:0]              tcrOut;
   logic [15:0]              readWord;
   logic                     csrClr;
   logic                     mse;
   logic [LINE_BITS-1:0]     tline;
   logic                     txTaken;

   //////////////////////////////////////////////////////////////////////
   // Bus swap and offset decode
   //////////////////////////////////////////////////////////////////////

   // Bus bit 0 is the MSB, positional copy flips the numbering
   assign busIn  = devDataIn;
   // Device registers live in the low 16 bits
   assign wrData = busIn[15:0];

   assign csrWrite = devWrite && (devAddr == `DZ_OFS_CSR);
   assign lprWrite = devWrite && (devAddr == `DZ_OFS_LPR);
   assign tcrWrite = devWrite && (devAddr == `DZ_OFS_TCR);
   assign tdrWrite = devWrite && (devAddr == `DZ_OFS_TDR);

   //////////////////////////////////////////////////////////////////////
   // Register blocks
   //////////////////////////////////////////////////////////////////////

   dzCsr uCsr (
      .clk      (clk),
      .reset    (reset),
      .devReset (devReset),
      .csrWrite (csrWrite),
      .loByte   (devLoByte),
      .hiByte   (devHiByte),
      .dataIn   (wrData),
      .tcrLin   (tcrOut[`DZ_LINES-1:0]),
      .txTaken  (txTaken),
      .csrOut   (csrOut),
      .csrClr   (csrClr),
      .mse      (mse),
      .tline    (tline)
   );

   dzTcr uTcr (
      .clk      (clk),
      .reset    (reset),
      .devReset (devReset),
      .tcrWrite (tcrWrite),
      .loByte   (devLoByte),
      .hiByte   (devHiByte),
      .dataIn   (wrData),
      .csrClr   (csrClr),
      .tcrOut   (tcrOut)
   );

   dzLineRegs uLineRegs (
      .clk      (clk),
      .reset    (reset),
      .devReset (devReset),
      .lprWrite (lprWrite),
      .tdrWrite (tdrWrite),
      .loByte   (devLoByte),
      .hiByte   (devHiByte),
      .dataIn   (wrData),
      .mse      (mse),
      .trdy     (csrOut.trdy),
      .tline    (tline),
      .txStrobe (txStrobe),
      .txLine   (txLine),
      .txChar   (txChar),
      .txTaken  (txTaken),
      .breakOut (breakOut),
      .rxEnable (rxEnable)
   );

   // DTR byte goes straight to the modem control pins
   assign dtrOut = tcrOut[15:8];

   //////////////////////////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////////////////////////

   // Offset 3 read shows modem status
   always_comb
   begin
      msrWord.msr.carrier = carrierIn;
      msrWord.msr.ring    = ringIn;
   end

   always_comb
   begin
      case (devAddr)
         `DZ_OFS_CSR: readWord = csrOut;
         `DZ_OFS_TCR: readWord = tcrOut;
         `DZ_OFS_TDR: readWord = msrWord;
         // LPR is write only
         default:     readWord = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset || devReset)
      begin
         devReadValid <= 1'b0;
         readData     <= '0;
      end
      else
      begin
         devReadValid <= devRead;
         if (devRead)
            readData <= {{(`DZ_BUS_WIDTH-16){1'b0}}, readWord};
      end
   end

   // Back to big-endian numbering
   assign devDataOut = readData;

   // One decoded register per bus write
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({csrWrite, lprWrite, tcrWrite, tdrWrite}));

endmodule

// File: rtl/dzTcr.sv
//////////////////////////////////////////////////////////////////////
// Transmit control register, DTR in the high byte, line enables low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "dzCfg.svh"

module dzTcr (
   input  logic        clk,
   input  logic        reset,
   input  logic        devReset,
   input  logic        tcrWrite,
   input  logic        loByte,
   input  logic        hiByte,
   input  logic [15:0] dataIn,
   input  logic        csrClr,
   output logic [15:0] tcrOut
);

   // Data terminal ready, one bit per line
   logic [`DZ_LINES-1:0] tcrDtr;
   // Transmit line enables
   logic [`DZ_LINES-1:0] tcrLin;

   always_ff @(posedge clk)
   begin
      if (reset || devReset)
      begin
         tcrDtr <= '0;
         tcrLin <= '0;
      end
      else if (csrClr)
         // DTR survives a CSR clear, modem lines stay up
         tcrLin <= '0;
      else if (tcrWrite)
      begin
         // Byte lanes independent
         if (hiByte)
            tcrDtr <= dataIn[15:8];
         if (loByte)
            tcrLin <= dataIn[7:0];
      end
   end

   assign tcrOut = {tcrDtr, tcrLin};

endmodule

// File: verif/dzRegsInput.txt
// Columns: op_offset_byteEnables_data_expected, hex; enables bit 1 high byte, bit 0 low byte
// Ops: 1 write, 2 read, 3 tx write, 4 ignored tx write, 5 modem in, 6 break, 7 rxEnable, 8 dtr, 9 strobe, a devReset, f end
2_0_0_0000_0000
2_1_0_0000_0000
2_2_0_0000_0000
2_3_0_0000_0000
9_0_0_0000_0000
6_0_0_0000_0000
7_0_0_0000_0000
// TCR byte lanes
1_2_3_a53c_0000
2_2_0_0000_a53c
8_0_0_0000_00a5
1_2_1_ff0f_0000
2_2_0_0000_a50f
1_2_2_5aff_0000
2_2_0_0000_5a0f
// CSR enables then clear
1_0_3_5060_0000
2_0_0_0000_d060
1_0_1_0070_0000
2_0_0_0000_0000
2_2_0_0000_5a00
// Lines 2, 5 and 7 enabled, scan wraps back to 2
1_2_1_00a4_0000
1_0_1_0020_0000
2_0_0_0000_8220
3_3_1_0041_0241
3_3_1_0042_0542
3_3_1_0043_0743
3_3_1_0044_0244
1_0_1_0000_0000
4_3_1_0055_0000
// Modem status and break
5_0_0_813c_0000
2_3_0_0000_813c
1_3_2_9600_0000
6_0_0_0000_0096
// Line parameters, receivers gated by mse
1_1_3_1e1b_0000
7_0_0_0000_0000
1_0_1_0020_0000
7_0_0_0000_0008
1_1_3_0e1e_0000
1_1_3_1001_0000
7_0_0_0000_000a
2_1_0_0000_0000
1_0_1_0000_0000
7_0_0_0000_0000
// Device reset
a_0_0_0000_0000
2_0_0_0000_0000
2_2_0_0000_0000
6_0_0_0000_0000
8_0_0_0000_0000
f_0_0_0000_0000

// File: verif/dzRegsTb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the register block with one bus operation per data line
// Run from the project root so the input file path resolves
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "dzCfg.svh"

module dzRegsTb;

   localparam int LINE_BITS  = $clog2(`DZ_LINES);
   localparam int OP_DEPTH   = 64;
   // Cycles any single wait may take
   localparam int WAIT_LIMIT = 16;

   // Operation codes of the input file
   localparam logic [3:0] OP_WRITE     = 4'h1;
   localparam logic [3:0] OP_READ      = 4'h2;
   localparam logic [3:0] OP_TX        = 4'h3;
   localparam logic [3:0] OP_NO_TX     = 4'h4;
   localparam logic [3:0] OP_MODEM     = 4'h5;
   localparam logic [3:0] OP_BREAK     = 4'h6;
   localparam logic [3:0] OP_RX_EN     = 4'h7;
   localparam logic [3:0] OP_DTR       = 4'h8;
   localparam logic [3:0] OP_STROBE    = 4'h9;
   localparam logic [3:0] OP_DEV_RESET = 4'ha;
   localparam logic [3:0] OP_END       = 4'hf;

   logic                     clk;
   logic                     reset;
   logic                     devReset;
   logic                     devWrite;
   logic                     devRead;
   logic                     devLoByte;
   logic                     devHiByte;
   logic [1:0]               devAddr;
   logic [0:`DZ_BUS_WIDTH-1] devDataIn;
   logic [0:`DZ_BUS_WIDTH-1] devDataOut;
   logic                     devReadValid;
   logic                     txStrobe;
   logic [LINE_BITS-1:0]     txLine;
   logic [7:0]               txChar;
   logic [`DZ_LINES-1:0]     breakOut;
   logic [`DZ_LINES-1:0]     dtrOut;
   logic [`DZ_LINES-1:0]     rxEnable;
   logic [`DZ_LINES-1:0]     carrierIn;
   logic [`DZ_LINES-1:0]     ringIn;

   // Op, offset, byte enables, data, expected
   logic [43:0]              opMem [0:OP_DEPTH-1];

   dzRegs DUT (
      .clk          (clk),
      .reset        (reset),
      .devReset     (devReset),
      .devWrite     (devWrite),
      .devRead      (devRead),
      .devLoByte    (devLoByte),
      .devHiByte    (devHiByte),
      .devAddr      (devAddr),
      .devDataIn    (devDataIn),
      .devDataOut   (devDataOut),
      .devReadValid (devReadValid),
      .txStrobe     (txStrobe),
      .txLine       (txLine),
      .txChar       (txChar),
      .breakOut     (breakOut),
      .dtrOut       (dtrOut),
      .rxEnable     (rxEnable),
      .carrierIn    (carrierIn),
      .ringIn       (ringIn)
   );

   // 8 ns clock
   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   task automatic abortRun();
      $display("test failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic checkWord(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
         abortRun();
      end
   endtask

   // Whole CSR word with tline printed apart as it moves with the scanner
   task automatic checkCsr(input dzPkg::csrT got, input dzPkg::csrT exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: csrOut got %h (tline %0d) expected %h (tline %0d)",
                  $time, got, got.tline, exp, exp.tline);
         abortRun();
      end
   endtask

   task automatic checkTx(input logic [LINE_BITS-1:0] gotLine, input logic [7:0] gotChar,
                          input logic [LINE_BITS-1:0] expLine, input logic [7:0] expChar);
      if (gotLine !== expLine || gotChar !== expChar)
      begin
         $display("Fail at %0t ns: txLine got %0d expected %0d, txChar got %h expected %h",
                  $time, gotLine, expLine, gotChar, expChar);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus operations driven on the falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic busWrite(input logic [1:0] ofs, input logic [1:0] be,
                           input logic [15:0] data);
      @(negedge clk);
      devAddr   = ofs;
      devHiByte = be[1];
      devLoByte = be[0];
      devDataIn = {{(`DZ_BUS_WIDTH-16){1'b0}}, data};
      devWrite  = 1'b1;
      @(negedge clk);
      devWrite  = 1'b0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
   endtask

   task automatic busRead(input logic [1:0] ofs, output logic [15:0] word);
      int                       waits;
      logic [`DZ_BUS_WIDTH-1:0] readBus;
      @(negedge clk);
      // Valid marks only the cycle after a read, idle otherwise
      checkWord("devReadValid", {15'd0, devReadValid}, 16'h0000);
      devAddr = ofs;
      devRead = 1'b1;
      @(negedge clk);
      devRead = 1'b0;
      waits   = 0;
      while (!devReadValid && waits < WAIT_LIMIT)
      begin
         @(negedge clk);
         waits++;
      end
      if (!devReadValid)
      begin
         $display("Timeout: no devReadValid after a read of offset %0d", ofs);
         abortRun();
      end
      // Register sits in the low 16 bits of the little-endian copy
      readBus = devDataOut;
      word    = readBus[15:0];
   endtask

   // Character write that must come out on the transmit strobe
   task automatic txWrite(input logic [1:0] ofs, input logic [1:0] be,
                          input logic [15:0] data, input logic [15:0] exp);
      int waits;
      busWrite(ofs, be, data);
      waits = 0;
      while (!txStrobe && waits < WAIT_LIMIT)
      begin
         @(negedge clk);
         waits++;
      end
      if (!txStrobe)
      begin
         $display("Timeout: no txStrobe after a TDR write with data %h", data);
         abortRun();
      end
      checkTx(txLine, txChar, exp[LINE_BITS+7:8], exp[7:0]);
   endtask

   // Strobe would show one cycle after the write so watch a little past that
   task automatic noTxWrite(input logic [1:0] ofs, input logic [1:0] be,
                            input logic [15:0] data);
      busWrite(ofs, be, data);
      for (int i = 0; i < 2; i++)
      begin
         checkWord("txStrobe", {15'd0, txStrobe}, 16'h0000);
         @(negedge clk);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [43:0] entry;
      logic [3:0]  op;
      logic [1:0]  ofs;
      logic [1:0]  be;
      logic [15:0] data;
      logic [15:0] expWord;
      logic [15:0] word;
      int          idx;
      logic        done;
      clk       = 1'b0;
      reset     = 1'b1;
      devReset  = 1'b0;
      devWrite  = 1'b0;
      devRead   = 1'b0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
      devAddr   = 2'd0;
      devDataIn = '0;
      carrierIn = '0;
      ringIn    = '0;
      $readmemh("verif/dzRegsInput.txt", opMem);
      // Reset held for three clock cycles
      repeat (3) @(negedge clk);
      reset = 1'b0;
      done  = 1'b0;
      idx   = 0;
      while (!done && idx < OP_DEPTH)
      begin
         entry   = opMem[idx];
         op      = entry[43:40];
         ofs     = entry[37:36];
         be      = entry[33:32];
         data    = entry[31:16];
         expWord = entry[15:0];
         case (op)
            OP_WRITE: busWrite(ofs, be, data);
            OP_READ:
            begin
               busRead(ofs, word);
               if (ofs == `DZ_OFS_CSR)
                  checkCsr(word, expWord);
               else
                  checkWord("devDataOut", word, expWord);
            end
            OP_TX:    txWrite(ofs, be, data, expWord);
            OP_NO_TX: noTxWrite(ofs, be, data);
            OP_MODEM:
            begin
               @(negedge clk);
               carrierIn = data[15:8];
               ringIn    = data[7:0];
            end
            OP_BREAK:
            begin
               @(negedge clk);
               checkWord("breakOut", {8'd0, breakOut}, expWord);
            end
            OP_RX_EN:
            begin
               @(negedge clk);
               checkWord("rxEnable", {8'd0, rxEnable}, expWord);
            end
            OP_DTR:
            begin
               @(negedge clk);
               checkWord("dtrOut", {8'd0, dtrOut}, expWord);
            end
            OP_STROBE:
            begin
               @(negedge clk);
               checkWord("txStrobe", {15'd0, txStrobe}, expWord);
            end
            OP_DEV_RESET:
            begin
               @(negedge clk);
               devReset = 1'b1;
               @(negedge clk);
               devReset = 1'b0;
            end
            OP_END:   done = 1'b1;
            default:
            begin
               $display("Unknown operation code %h in input entry %0d", op, idx);
               abortRun();
            end
         endcase
         idx++;
      end
      if (!done)
      begin
         $display("Input file ran out without an end marker");
         abortRun();
      end
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule
